// File: cp0.f
+incdir+.
cp0_pkg.sv
cp0_if.sv
cp0_exc_unit.sv
cp0_status_reg.sv
cp0_timer_int.sv
cp0_read_mux.sv
cp0_top.sv
tb_cp0.sv

// File: cp0_config.svh
`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

// Register addresses are {rd, sel} as encoded in mtc0/mfc0

`define CP0_ADDR_BADVADDR {5'd8,  3'd0}
`define CP0_ADDR_COUNT    {5'd9,  3'd0}
`define CP0_ADDR_COMPARE  {5'd11, 3'd0}
`define CP0_ADDR_STATUS   {5'd12, 3'd0}
`define CP0_ADDR_CAUSE    {5'd13, 3'd0}
`define CP0_ADDR_EPC      {5'd14, 3'd0}
`define CP0_ADDR_PRID     {5'd15, 3'd0}
`define CP0_ADDR_EBASE    {5'd15, 3'd1}

// Fixed processor identification word
`define CP0_PRID_VAL      32'h0000_4220

// EBase comes out of reset in kseg0
`define CP0_EBASE_RST     32'h8000_0000

// Compare starts at its maximum so TI stays quiet after reset
`define CP0_COMPARE_RST   32'hFFFF_FFFF

// Exception entry while Bev is set
`define CP0_BOOT_EX_BASE  32'hBFC0_0200

// Offset of the general exception vector, refills use offset zero
`define CP0_GEN_EX_OFFSET 32'h0000_0180

// Hardware interrupt lines into Cause.IP[7:2]
`define CP0_NUM_EXT_INT   6

`endif

// File: cp0_exc_unit.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module cp0_exc_unit import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       commit_valid,
    input  logic       inst_mtc0,
    input  logic       inst_eret,
    input  logic [4:0] rd_idx,
    input  logic [2:0] sel,
    input  word_t      wr_data,
    input  word_t      pc,
    input  word_t      alu_result,
    input  logic       bd,
    input  logic       ex,
    input  exc_type_t  exc_type,
    cp0_cmd_if.src     cmd,
    cp0_view_if.exc_mp view,
    output logic       eret_flush,
    output word_t      exc_vector
);

    localparam cp0_addr_t EPC_ADDR   = `CP0_ADDR_EPC;
    localparam cp0_addr_t EBASE_ADDR = `CP0_ADDR_EBASE;

    logic  itlb_type;
    logic  dtlb_type;
    logic  refill_type;
    word_t ex_base;

    function automatic exc_code_t map_exc_code(input exc_type_t t);
        case (t)
            EXC_INT:             return EC_INT;
            EXC_ITLB_REFILL,
            EXC_ITLB_INVALID,
            EXC_DTLB_RD_REFILL,
            EXC_DTLB_RD_INVALID: return EC_TLBL;
            EXC_DTLB_WR_REFILL,
            EXC_DTLB_WR_INVALID: return EC_TLBS;
            EXC_DTLB_MOD:        return EC_MOD;
            EXC_ADEL:            return EC_ADEL;
            EXC_ADES:            return EC_ADES;
            EXC_SYS:             return EC_SYS;
            EXC_BP:              return EC_BP;
            EXC_RI:              return EC_RI;
            EXC_CPU:             return EC_CPU;
            EXC_OV:              return EC_OV;
            EXC_TRAP:            return EC_TR;
            default:             return EC_NONE;
        endcase
    endfunction

    // Commit qualification, exception kills the write and the eret
    assign cmd.wr_en    = commit_valid & inst_mtc0 & ~ex;
    assign cmd.eret     = commit_valid & inst_eret & ~ex;
    assign cmd.ex       = commit_valid & ex;
    assign cmd.addr     = {rd_idx, sel};
    assign cmd.wr_data  = wr_data;
    assign cmd.exc_type = exc_type;
    assign eret_flush   = cmd.eret;

    assign itlb_type = (exc_type == EXC_ITLB_REFILL) || (exc_type == EXC_ITLB_INVALID);
    assign dtlb_type = (exc_type == EXC_DTLB_RD_REFILL) || (exc_type == EXC_DTLB_RD_INVALID) ||
                       (exc_type == EXC_DTLB_WR_REFILL) || (exc_type == EXC_DTLB_WR_INVALID) ||
                       (exc_type == EXC_DTLB_MOD);
    assign refill_type = (exc_type == EXC_ITLB_REFILL) || (exc_type == EXC_DTLB_RD_REFILL) ||
                         (exc_type == EXC_DTLB_WR_REFILL);

    assign ex_base    = view.bev ? `CP0_BOOT_EX_BASE : view.ebase;
    assign exc_vector = ex_base + (refill_type ? 32'd0 : `CP0_GEN_EX_OFFSET);

    // EPC and BD are frozen while already in exception level
    always_ff @(posedge clk) begin
        if (cmd.ex && !view.exl) begin
            view.epc <= bd ? pc - 32'd4 : pc; // Delay slot points back at the branch
        end else if (cmd.wr_en && cmd.addr == EPC_ADDR) begin
            view.epc <= cmd.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.ex) begin
            if (cmd.exc_type == EXC_ADES || dtlb_type) begin
                view.badvaddr <= alu_result;
            end else if (cmd.exc_type == EXC_ADEL) begin
                view.badvaddr <= (pc[1:0] != 2'b00) ? pc : alu_result; // Fetch or load
            end else if (itlb_type) begin
                view.badvaddr <= pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            view.bd       <= 1'b0;
            view.ce       <= 2'b00;
            view.exc_code <= EC_NONE;
            view.ebase    <= `CP0_EBASE_RST;
        end else begin
            if (cmd.ex && !view.exl) begin
                view.bd <= bd;
            end
            if (cmd.ex) begin
                view.exc_code <= map_exc_code(cmd.exc_type);
                if (cmd.exc_type == EXC_CPU) begin
                    view.ce <= 2'b01; // Only CP1 can be unusable here
                end
            end
            if (cmd.wr_en && cmd.addr == EBASE_ADDR) begin
                view.ebase[29:12] <= cmd.wr_data[29:12]; // Exception base field only
            end
        end
    end

    // A committed exception always carries its cause
    a_ex_has_type: assert property (@(posedge clk) disable iff (reset)
        cmd.ex |-> (cmd.exc_type != EXC_NONE));

endmodule

// File: cp0_if.sv
`timescale 1ns/10ps

// Qualified commit-stage command, one producer and several consumers
interface cp0_cmd_if import cp0_pkg::*; ();
    logic      wr_en;    // mtc0 committed without exception
    cp0_addr_t addr;     // mtc0 target and mfc0 source
    word_t     wr_data;
    logic      ex;       // Exception taken at commit
    logic      eret;     // eret committed without exception
    exc_type_t exc_type;

    modport src (output wr_en, addr, wr_data, ex, eret, exc_type);
    modport snk (input  wr_en, addr, wr_data, ex, eret, exc_type);
endinterface

// Register contents, each field driven by the unit that owns it
interface cp0_view_if import cp0_pkg::*; ();
    logic      cu0;
    logic      bev;
    int_mask_t im;
    logic      um;
    logic      erl;
    logic      exl;
    logic      ie;

    word_t     epc;
    word_t     badvaddr;
    logic      bd;
    logic [1:0] ce;
    exc_code_t exc_code;
    word_t     ebase;

    word_t     count;
    word_t     compare;
    logic      ti;
    int_mask_t ip;

    modport status_mp (output cu0, bev, im, um, erl, exl, ie);
    modport exc_mp    (output epc, badvaddr, bd, ce, exc_code, ebase,
                       input  exl, bev);
    modport timer_mp  (output count, compare, ti, ip);
    modport rd_mp     (input  cu0, bev, im, um, erl, exl, ie,
                              epc, badvaddr, bd, ce, exc_code, ebase,
                              count, compare, ti, ip);
endinterface

// File: cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;     // Data or virtual address
    typedef logic [7:0]  cp0_addr_t; // {rd, sel}
    typedef logic [7:0]  int_mask_t; // Status.IM and Cause.IP

    // Exception type as reported by the pipeline at commit
    typedef enum logic [4:0] {
        EXC_NONE            = 5'd0,
        EXC_INT             = 5'd1,
        EXC_ITLB_REFILL     = 5'd2,
        EXC_ITLB_INVALID    = 5'd3,
        EXC_DTLB_RD_REFILL  = 5'd4,
        EXC_DTLB_RD_INVALID = 5'd5,
        EXC_DTLB_WR_REFILL  = 5'd6,
        EXC_DTLB_WR_INVALID = 5'd7,
        EXC_DTLB_MOD        = 5'd8,
        EXC_ADEL            = 5'd9,
        EXC_ADES            = 5'd10,
        EXC_SYS             = 5'd11,
        EXC_BP              = 5'd12,
        EXC_RI              = 5'd13,
        EXC_CPU             = 5'd14,
        EXC_OV              = 5'd15,
        EXC_TRAP            = 5'd16
    } exc_type_t;

    // Architectural Cause.ExcCode values
    typedef enum logic [4:0] {
        EC_INT  = 5'd0,
        EC_MOD  = 5'd1,
        EC_TLBL = 5'd2,
        EC_TLBS = 5'd3,
        EC_ADEL = 5'd4,
        EC_ADES = 5'd5,
        EC_SYS  = 5'd8,
        EC_BP   = 5'd9,
        EC_RI   = 5'd10,
        EC_CPU  = 5'd11,
        EC_OV   = 5'd12,
        EC_TR   = 5'd13,
        EC_NONE = 5'd31  // Reset value, no exception seen yet
    } exc_code_t;

endpackage

// File: cp0_read_mux.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module cp0_read_mux import cp0_pkg::*; (
    cp0_cmd_if.snk      cmd,
    cp0_view_if.rd_mp   view,
    output word_t       rd_data
);

    word_t status_word;
    word_t cause_word;

    // Pack the fields into their architectural positions
    assign status_word = {3'b000, view.cu0, 5'b00000, view.bev, 6'b000000,
                          view.im, 3'b000, view.um, 1'b0, view.erl,
                          view.exl, view.ie};

    assign cause_word = {view.bd, view.ti, view.ce, 12'h000, view.ip,
                         1'b0, view.exc_code, 2'b00};

    always_comb begin
        case (cmd.addr)
            `CP0_ADDR_BADVADDR: rd_data = view.badvaddr;
            `CP0_ADDR_COUNT:    rd_data = view.count;
            `CP0_ADDR_COMPARE:  rd_data = view.compare;
            `CP0_ADDR_STATUS:   rd_data = status_word;
            `CP0_ADDR_CAUSE:    rd_data = cause_word;
            `CP0_ADDR_EPC:      rd_data = view.epc;
            `CP0_ADDR_PRID:     rd_data = `CP0_PRID_VAL;
            `CP0_ADDR_EBASE:    rd_data = view.ebase;
            default:            rd_data = '0; // TLB and config registers are absent
        endcase
    end

    // A write with a floating address would silently hit some register
    always_comb begin
        a_addr_known: assert final (!(cmd.wr_en && $isunknown(cmd.addr)));
    end

endmodule

// File: cp0_status_reg.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module cp0_status_reg import cp0_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    cp0_cmd_if.snk        cmd,
    cp0_view_if.status_mp view
);

    localparam cp0_addr_t STATUS_ADDR = `CP0_ADDR_STATUS;

    logic status_wr;

    assign status_wr = cmd.wr_en && (cmd.addr == STATUS_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            view.cu0 <= 1'b0;
            view.bev <= 1'b1;  // Boot vectors until software clears it
            view.im  <= '0;
            view.um  <= 1'b0;
            view.erl <= 1'b0;
            view.ie  <= 1'b0;
        end else if (status_wr) begin
            view.cu0 <= cmd.wr_data[28];
            view.bev <= cmd.wr_data[22];
            view.im  <= cmd.wr_data[15:8];
            view.um  <= cmd.wr_data[4];
            view.erl <= cmd.wr_data[2];
            view.ie  <= cmd.wr_data[0];
        end
    end

    // EXL has its own priority: exception, then eret, then mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            view.exl <= 1'b0;
        end else if (cmd.ex) begin
            view.exl <= 1'b1;
        end else if (cmd.eret) begin
            view.exl <= 1'b0;
        end else if (status_wr) begin
            view.exl <= cmd.wr_data[1];
        end
    end

    // eret only makes sense from exception or error level
    a_eret_in_exl: assert property (@(posedge clk) disable iff (reset)
        cmd.eret |-> (view.exl || view.erl));

endmodule

// File: cp0_timer_int.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module cp0_timer_int import cp0_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`CP0_NUM_EXT_INT-1:0] ext_int,
    cp0_cmd_if.snk                      cmd,
    cp0_view_if.timer_mp                view
);

    localparam cp0_addr_t COUNT_ADDR   = `CP0_ADDR_COUNT;
    localparam cp0_addr_t COMPARE_ADDR = `CP0_ADDR_COMPARE;
    localparam cp0_addr_t CAUSE_ADDR   = `CP0_ADDR_CAUSE;

    logic tick;        // Count advances when this is high
    logic count_wr;
    logic compare_wr;
    logic cause_wr;

    assign count_wr   = cmd.wr_en && (cmd.addr == COUNT_ADDR);
    assign compare_wr = cmd.wr_en && (cmd.addr == COMPARE_ADDR);
    assign cause_wr   = cmd.wr_en && (cmd.addr == CAUSE_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick       <= 1'b0;
            view.count <= '0;
        end else begin
            tick <= ~tick; // Half the core clock
            if (count_wr) begin
                view.count <= cmd.wr_data;
            end else if (tick) begin
                view.count <= view.count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            view.compare <= `CP0_COMPARE_RST;
            view.ti      <= 1'b0;
        end else begin
            if (compare_wr) begin
                view.compare <= cmd.wr_data;
            end
            // Writing Compare acknowledges the timer interrupt
            if (compare_wr) begin
                view.ti <= 1'b0;
            end else if (view.count == view.compare) begin
                view.ti <= 1'b1;
            end
        end
    end

    // IP7 shares the last hardware line with the timer
    always_ff @(posedge clk) begin
        if (reset) begin
            view.ip <= '0;
        end else begin
            view.ip[7]   <= ext_int[`CP0_NUM_EXT_INT-1] | view.ti;
            view.ip[6:2] <= ext_int[`CP0_NUM_EXT_INT-2:0];
            if (cause_wr) begin
                view.ip[1:0] <= cmd.wr_data[9:8]; // Software interrupts
            end
        end
    end

endmodule

// File: cp0_top.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module cp0_top import cp0_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        commit_valid,
    input  logic                        inst_mtc0,
    input  logic                        inst_eret,
    input  logic [4:0]                  rd_idx,
    input  logic [2:0]                  sel,
    input  word_t                       wr_data,
    input  word_t                       pc,
    input  word_t                       alu_result,
    input  logic                        bd,
    input  logic                        ex,
    input  exc_type_t                   exc_type,
    input  logic [`CP0_NUM_EXT_INT-1:0] ext_int,
    output word_t                       rd_data,
    output logic                        eret_flush,
    output word_t                       epc,
    output logic                        status_ie,
    output logic                        status_exl,
    output int_mask_t                   status_im,
    output int_mask_t                   cause_ip,
    output logic                        cause_ti,
    output word_t                       exc_vector
);

    cp0_cmd_if  cmd_if ();
    cp0_view_if view_if ();

    cp0_exc_unit exc_unit_i (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .inst_mtc0    (inst_mtc0),
        .inst_eret    (inst_eret),
        .rd_idx       (rd_idx),
        .sel          (sel),
        .wr_data      (wr_data),
        .pc           (pc),
        .alu_result   (alu_result),
        .bd           (bd),
        .ex           (ex),
        .exc_type     (exc_type),
        .cmd          (cmd_if.src),
        .view         (view_if.exc_mp),
        .eret_flush   (eret_flush),
        .exc_vector   (exc_vector)
    );

    cp0_status_reg status_reg_i (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_if.snk),
        .view  (view_if.status_mp)
    );

    cp0_timer_int timer_int_i (
        .clk     (clk),
        .reset   (reset),
        .ext_int (ext_int),
        .cmd     (cmd_if.snk),
        .view    (view_if.timer_mp)
    );

    cp0_read_mux read_mux_i (
        .cmd     (cmd_if.snk),
        .view    (view_if.rd_mp),
        .rd_data (rd_data)
    );

    // Pipeline-facing copies of the live register fields
    assign epc        = view_if.epc;
    assign status_ie  = view_if.ie;
    assign status_exl = view_if.exl;
    assign status_im  = view_if.im;
    assign cause_ip   = view_if.ip;
    assign cause_ti   = view_if.ti;

endmodule

// File: tb_cp0.sv
`timescale 1ns/10ps

`include "cp0_config.svh"

module tb_cp0 import cp0_pkg::*; ();

    localparam int CLK_PERIOD = 100;

    typedef enum {OP_WR, OP_RD, OP_EX, OP_ERET, OP_IDLE, OP_VEC, OP_EXT, OP_RNG, OP_TI} op_t;

    typedef struct {
        string     name;
        op_t       op;
        cp0_addr_t addr;
        word_t     data;  // Write data, alu_result, idle count or wait bound
        word_t     exp;
        word_t     mask;
        exc_type_t etype;
        word_t     pc;
        logic      bd;
    } entry_t;

    logic       clk;
    logic       reset;
    logic       commit_valid;
    logic       inst_mtc0;
    logic       inst_eret;
    logic [4:0] rd_idx;
    logic [2:0] sel;
    word_t      wr_data;
    word_t      pc;
    word_t      alu_result;
    logic       bd;
    logic       ex;
    exc_type_t  exc_type;
    logic [5:0] ext_int;
    word_t      rd_data;
    logic       eret_flush;
    word_t      epc;
    logic       status_ie;
    logic       status_exl;
    int_mask_t  status_im;
    int_mask_t  cause_ip;
    logic       cause_ti;
    word_t      exc_vector;

    entry_t tbl[$];
    logic   tbl_ready = 1'b0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    word_t  lcg_state = 32'h378a;

    cp0_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void add_entry(string name, op_t op, cp0_addr_t addr, word_t data,
                                      word_t exp, word_t mask = '1,
                                      exc_type_t etype = EXC_NONE, word_t pc_v = '0,
                                      logic bd_v = 1'b0);
        entry_t e;
        e.name  = name;
        e.op    = op;
        e.addr  = addr;
        e.data  = data;
        e.exp   = exp;
        e.mask  = mask;
        e.etype = etype;
        e.pc    = pc_v;
        e.bd    = bd_v;
        tbl.push_back(e);
    endfunction

    // EPC and the Status fields that the DUT also drives as dedicated outputs
    function automatic word_t port_word(input cp0_addr_t addr);
        if (addr == `CP0_ADDR_EPC) begin
            return epc;
        end else if (addr == `CP0_ADDR_STATUS) begin
            return {16'd0, status_im, 6'd0, status_exl, status_ie};
        end
        return '0;
    endfunction

    function automatic word_t port_mask(input cp0_addr_t addr);
        if (addr == `CP0_ADDR_EPC) begin
            return '1;
        end else if (addr == `CP0_ADDR_STATUS) begin
            return 32'h0000_FF03; // IM, EXL and IE
        end
        return '0;
    endfunction

    task automatic build_table();
        word_t r;
        word_t ebase_val;
        add_entry("rst_status", OP_RD, `CP0_ADDR_STATUS, 0, 32'h0040_0000);
        add_entry("rst_compare", OP_RD, `CP0_ADDR_COMPARE, 0, 32'hFFFF_FFFF);
        add_entry("rst_prid", OP_RD, `CP0_ADDR_PRID, 0, 32'h0000_4220);
        add_entry("rst_ebase", OP_RD, `CP0_ADDR_EBASE, 0, 32'h8000_0000);
        add_entry("rst_exccode", OP_RD, `CP0_ADDR_CAUSE, 0, 32'd31 << 2, 32'h0000_007C);
        add_entry("rst_vec_sys", OP_VEC, 0, 0, 32'hBFC0_0380, '1, EXC_SYS);
        r = lcg_next();
        add_entry("wr_status", OP_WR, `CP0_ADDR_STATUS, r, 0);
        add_entry("rd_status", OP_RD, `CP0_ADDR_STATUS, 0, r & 32'h1040_FF17);
        r = lcg_next();
        add_entry("wr_epc", OP_WR, `CP0_ADDR_EPC, r, 0);
        add_entry("rd_epc", OP_RD, `CP0_ADDR_EPC, 0, r);
        r = lcg_next();
        ebase_val = 32'h8000_0000 | (r & 32'h3FFF_F000); // Only bits 29:12 writable
        add_entry("wr_ebase", OP_WR, `CP0_ADDR_EBASE, r, 0);
        add_entry("rd_ebase", OP_RD, `CP0_ADDR_EBASE, 0, ebase_val);
        r = lcg_next();
        add_entry("wr_cause", OP_WR, `CP0_ADDR_CAUSE, r, 0);
        add_entry("rd_cause", OP_RD, `CP0_ADDR_CAUSE, 0, (r & 32'h300) | 32'h7C);
        add_entry("restore_status", OP_WR, `CP0_ADDR_STATUS, 32'h0040_0000, 0);
        // Exceptions, every exception op also carries an mtc0 that must be dropped
        add_entry("ex_kills_wr", OP_EX, `CP0_ADDR_EBASE, lcg_next(), 0, '1, EXC_SYS,
                  32'h0000_1000, 1'b0);
        add_entry("ebase_kept", OP_RD, `CP0_ADDR_EBASE, 0, ebase_val);
        add_entry("exl_set", OP_RD, `CP0_ADDR_STATUS, 0, 32'h2, 32'h2);
        add_entry("code_sys", OP_RD, `CP0_ADDR_CAUSE, 0, 32'd8 << 2, 32'h8000_007C);
        add_entry("epc_pc", OP_RD, `CP0_ADDR_EPC, 0, 32'h0000_1000);
        add_entry("ex_nested", OP_EX, 0, 0, 0, '1, EXC_BP, 32'h0000_2000, 1'b1);
        add_entry("epc_frozen", OP_RD, `CP0_ADDR_EPC, 0, 32'h0000_1000);
        add_entry("bd_frozen", OP_RD, `CP0_ADDR_CAUSE, 0, 32'd9 << 2, 32'h8000_007C);
        add_entry("eret_a", OP_ERET, 0, 0, 1);
        add_entry("exl_clr", OP_RD, `CP0_ADDR_STATUS, 0, 0, 32'h2);
        add_entry("ex_delay_slot", OP_EX, 0, 0, 0, '1, EXC_RI, 32'h0000_3000, 1'b1);
        add_entry("epc_minus4", OP_RD, `CP0_ADDR_EPC, 0, 32'h0000_2FFC);
        add_entry("bd_set", OP_RD, `CP0_ADDR_CAUSE, 0, 32'h8000_0028, 32'h8000_007C);
        add_entry("eret_b", OP_ERET, 0, 0, 1);
        add_entry("ex_adel_fetch", OP_EX, 0, 32'h1234_5678, 0, '1, EXC_ADEL, 32'h0000_4002);
        add_entry("badv_pc", OP_RD, `CP0_ADDR_BADVADDR, 0, 32'h0000_4002);
        add_entry("eret_c", OP_ERET, 0, 0, 1);
        add_entry("ex_dtlb", OP_EX, 0, 32'hCAFE_0010, 0, '1, EXC_DTLB_RD_REFILL, 32'h5000);
        add_entry("badv_alu", OP_RD, `CP0_ADDR_BADVADDR, 0, 32'hCAFE_0010);
        add_entry("code_tlbl", OP_RD, `CP0_ADDR_CAUSE, 0, 32'd2 << 2, 32'h0000_007C);
        add_entry("eret_d", OP_ERET, 0, 0, 1);
        // Vectors from EBase once Bev is cleared
        add_entry("bev_clr", OP_WR, `CP0_ADDR_STATUS, 0, 0);
        add_entry("wr_ebase_vec", OP_WR, `CP0_ADDR_EBASE, 32'h1234_5000, 0);
        ebase_val = 32'h9234_5000;
        add_entry("vec_itlb_refill", OP_VEC, 0, 0, ebase_val, '1, EXC_ITLB_REFILL);
        add_entry("vec_dtlb_wr_refill", OP_VEC, 0, 0, ebase_val, '1, EXC_DTLB_WR_REFILL);
        add_entry("vec_ov", OP_VEC, 0, 0, ebase_val + 32'h180, '1, EXC_OV);
        add_entry("vec_itlb_inv", OP_VEC, 0, 0, ebase_val + 32'h180, '1, EXC_ITLB_INVALID);
        // Timer
        add_entry("wr_count", OP_WR, `CP0_ADDR_COUNT, 32'h100, 0);
        add_entry("count_run", OP_RNG, `CP0_ADDR_COUNT, 7, 32'h100 + (7 + 1) / 2);
        add_entry("wr_count_ti", OP_WR, `CP0_ADDR_COUNT, 32'h200, 0);
        add_entry("wr_compare", OP_WR, `CP0_ADDR_COMPARE, 32'h205, 0);
        add_entry("ti_rise", OP_TI, 0, 2 * 5 + 2, 1); // Two edges per count step
        add_entry("wr_compare_ack", OP_WR, `CP0_ADDR_COMPARE, 32'hFFFF_FFFF, 0);
        add_entry("ti_clr", OP_RD, `CP0_ADDR_CAUSE, 0, 0, 32'h4000_0000);
        add_entry("settle", OP_IDLE, 0, 2, 0);
        // Interrupt lines and software bits
        add_entry("ext_a", OP_EXT, 0, 6'b101010, 6'b101010);
        add_entry("ext_b", OP_EXT, 0, 6'b010101, 6'b010101);
        add_entry("ext_off", OP_EXT, 0, 0, 0);
        add_entry("wr_sw_both", OP_WR, `CP0_ADDR_CAUSE, 32'h300, 0);
        add_entry("sw_both", OP_RD, `CP0_ADDR_CAUSE, 0, 32'h300, 32'h300);
        add_entry("wr_sw_one", OP_WR, `CP0_ADDR_CAUSE, 32'h100, 0);
        add_entry("sw_one", OP_RD, `CP0_ADDR_CAUSE, 0, 32'h100, 32'h300);
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            fail_cnt++;
        end else begin
            $display("PASS %s", name);
            pass_cnt++;
        end
    endtask

    task automatic report_done(input string name);
        $display("PASS %s", name); // Stimulus only
        pass_cnt++;
    endtask

    task automatic release_commit();
        commit_valid <= 1'b0;
        inst_mtc0    <= 1'b0;
        inst_eret    <= 1'b0;
        ex           <= 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        int n;
        word_t act;
        word_t pmask;
        case (e.op)
            OP_WR, OP_EX: begin
                @(posedge clk);
                commit_valid  <= 1'b1;
                inst_mtc0     <= 1'b1;
                ex            <= (e.op == OP_EX);
                {rd_idx, sel} <= e.addr;
                wr_data       <= e.data;
                alu_result    <= e.data;
                pc            <= e.pc;
                bd            <= e.bd;
                exc_type      <= e.etype;
                @(posedge clk);
                release_commit();
                report_done(e.name);
            end
            OP_ERET: begin
                @(posedge clk);
                commit_valid <= 1'b1;
                inst_eret    <= 1'b1;
                @(negedge clk);
                act = {31'd0, eret_flush};
                @(posedge clk);
                release_commit();
                check_value(e.name, e.exp, act);
            end
            OP_RD, OP_RNG: begin
                if (e.op == OP_RNG) begin
                    repeat (e.data) @(posedge clk);
                end
                @(posedge clk);
                {rd_idx, sel} <= e.addr;
                @(negedge clk);
                pmask = port_mask(e.addr) & e.mask;
                if ((port_word(e.addr) & pmask) !== (e.exp & pmask)) begin
                    $display("FAIL %s outputs expected %h actual %h", e.name, e.exp & pmask,
                             port_word(e.addr) & pmask);
                    fail_cnt++;
                end else if (e.op == OP_RD) begin
                    check_value(e.name, e.exp, rd_data & e.mask);
                end else if (rd_data < e.exp || rd_data > e.exp + 1) begin
                    $display("FAIL %s expected %h..%h actual %h", e.name, e.exp,
                             e.exp + 1, rd_data);
                    fail_cnt++;
                end else begin
                    $display("PASS %s", e.name);
                    pass_cnt++;
                end
            end
            OP_VEC: begin
                @(posedge clk);
                exc_type <= e.etype;
                @(negedge clk);
                check_value(e.name, e.exp, exc_vector);
            end
            OP_EXT: begin
                @(posedge clk);
                ext_int <= e.data[5:0];
                @(posedge clk);
                @(negedge clk);
                check_value(e.name, e.exp, {26'd0, cause_ip[7:2]});
            end
            OP_TI: begin
                n = 0;
                do begin
                    @(negedge clk);
                    n = n + 1;
                end while (!cause_ti && n < e.data);
                if (!cause_ti) begin
                    $display("FAIL %s: cause_ti stayed low for %0d cycles", e.name, n);
                    fail_cnt++;
                end else begin
                    n = 0;
                    do begin
                        @(negedge clk);
                        n = n + 1;
                    end while (!cause_ip[7] && n < 2); // IP7 lags TI by one edge
                    if (!cause_ip[7]) begin
                        $display("FAIL %s: cause_ip bit 7 did not follow TI", e.name);
                        fail_cnt++;
                    end else begin
                        $display("PASS %s", e.name);
                        pass_cnt++;
                    end
                end
            end
            default: begin
                repeat (e.data) @(posedge clk);
                report_done(e.name);
            end
        endcase
    endtask

    initial begin
        reset        = 1'b1;
        commit_valid = 1'b0;
        inst_mtc0    = 1'b0;
        inst_eret    = 1'b0;
        rd_idx       = '0;
        sel          = '0;
        wr_data      = '0;
        pc           = '0;
        alu_result   = '0;
        bd           = 1'b0;
        ex           = 1'b0;
        exc_type     = EXC_NONE;
        ext_int      = '0;
        build_table();
        tbl_ready = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        @(posedge clk);
        $display("Summary: %0d passed, %0d failed, %0d entries", pass_cnt, fail_cnt,
                 tbl.size());
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Allows 20 cycles per table entry
    initial begin
        wait (tbl_ready);
        #(tbl.size() * 20 * CLK_PERIOD);
        $display("Watchdog expired before the table finished");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
